//--- hdl/ps2Kbd_macros.svh
`ifndef PS2KBD_MACROS_SVH
`define PS2KBD_MACROS_SVH

`define PS2_FRAME_BITS 11
`define SCAN_W         8
`define CHAR_W         16
`define SYNC_STAGES    2

// Prefix bytes
`define CODE_EXT       8'hE0
`define CODE_BREAK     8'hF0
`define CODE_CAPS      8'h58

// Extended arrow keys, byte after E0
`define CODE_UP        8'h75
`define CODE_DOWN      8'h72
`define CODE_LEFT      8'h6B
`define CODE_RIGHT     8'h74

`define CHAR_UP        16'h0100
`define CHAR_DOWN      16'h0101
`define CHAR_LEFT      16'h0102
`define CHAR_RIGHT     16'h0103

`endif

//--- hdl/ps2KbdPkg.sv
`default_nettype none
`include "ps2Kbd_macros.svh"

package ps2KbdPkg;

    typedef logic [`SCAN_W-1:0] scanCodeT;
    typedef logic [`CHAR_W-1:0] charCodeT;

    typedef enum logic [1:0] {
        stNormal,
        stExtended,
        stRelease
    } decStateT;

    // US layout, caps acts as shift
    function automatic charCodeT translateScan(input scanCodeT sc, input logic caps);
        logic [15:0] pair;   // Plain char in high byte, shifted in low byte
        logic [7:0]  sel;
        case (sc)
            8'h1C: pair = 16'h6141;
            8'h32: pair = 16'h6242;
            8'h21: pair = 16'h6343;
            8'h23: pair = 16'h6444;
            8'h24: pair = 16'h6545;
            8'h2B: pair = 16'h6646;
            8'h34: pair = 16'h6747;
            8'h33: pair = 16'h6848;
            8'h43: pair = 16'h6949;
            8'h3B: pair = 16'h6A4A;
            8'h42: pair = 16'h6B4B;
            8'h4B: pair = 16'h6C4C;
            8'h3A: pair = 16'h6D4D;
            8'h31: pair = 16'h6E4E;
            8'h44: pair = 16'h6F4F;
            8'h4D: pair = 16'h7050;
            8'h15: pair = 16'h7151;
            8'h2D: pair = 16'h7252;
            8'h1B: pair = 16'h7353;
            8'h2C: pair = 16'h7454;
            8'h3C: pair = 16'h7555;
            8'h2A: pair = 16'h7656;
            8'h1D: pair = 16'h7757;
            8'h22: pair = 16'h7858;
            8'h35: pair = 16'h7959;
            8'h1A: pair = 16'h7A5A;
            8'h45: pair = 16'h3029;   // Digit row
            8'h16: pair = 16'h3121;
            8'h1E: pair = 16'h3240;
            8'h26: pair = 16'h3323;
            8'h25: pair = 16'h3424;
            8'h2E: pair = 16'h3525;
            8'h36: pair = 16'h365E;
            8'h3D: pair = 16'h3726;
            8'h3E: pair = 16'h382A;
            8'h46: pair = 16'h3928;
            8'h4E: pair = 16'h2D5F;   // Minus
            8'h55: pair = 16'h3D2B;
            8'h5D: pair = 16'h5C7C;   // Backslash
            8'h54: pair = 16'h5B7B;
            8'h5B: pair = 16'h5D7D;
            8'h4C: pair = 16'h3B3A;
            8'h52: pair = 16'h2722;
            8'h41: pair = 16'h2C3C;
            8'h49: pair = 16'h2E3E;
            8'h4A: pair = 16'h2F3F;
            8'h66: pair = 16'h0808;   // Backspace
            8'h29: pair = 16'h2020;   // Space
            8'h5A: pair = 16'h0A0A;   // Enter
            default: pair = 16'h0000;
        endcase
        sel = caps ? pair[7:0] : pair[15:8];
        return charCodeT'(sel);
    endfunction

endpackage

`default_nettype wire

//--- hdl/keyEventIf.sv
`timescale 1ns/1ps
`default_nettype none

interface keyEventIf;
    import ps2KbdPkg::*;

    logic     evValid;   // One pulse per good frame
    logic     evPress;   // Qualifies evValid
    scanCodeT evScan;
    charCodeT evChar;

    modport src (
        output evValid,
        output evPress,
        output evScan,
        output evChar
    );

    modport dst (
        input evValid,
        input evPress,
        input evScan,
        input evChar
    );
endinterface

`default_nettype wire

//--- hdl/ps2FrameRx.sv
`timescale 1ns/1ps
`default_nettype none
`include "ps2Kbd_macros.svh"

module ps2FrameRx (
    input  wire logic          fclk,
    input  wire logic          rst,
    input  wire logic          ps2Clk,
    input  wire logic          ps2Data,
    output logic               codeValid,
    output ps2KbdPkg::scanCodeT code
);
    import ps2KbdPkg::*;

    localparam int CntW = $clog2(`PS2_FRAME_BITS);

    logic [`SYNC_STAGES:0]   clkSync;   // Top stage holds the previous level
    logic [`SYNC_STAGES-1:0] dataSync;
    logic                    clkFall;
    logic                    dataBit;
    logic [CntW-1:0]         bitCnt;    // 0 waits for start, 10 is stop
    scanCodeT                shiftReg;
    logic                    parityBit;

    // Lines idle high
    always_ff @(posedge fclk or negedge rst) begin
        if (!rst) begin
            clkSync  <= '1;
            dataSync <= '1;
        end else begin
            clkSync  <= {clkSync[`SYNC_STAGES-1:0], ps2Clk};
            dataSync <= {dataSync[`SYNC_STAGES-2:0], ps2Data};
        end
    end

    assign clkFall = clkSync[`SYNC_STAGES] & ~clkSync[`SYNC_STAGES-1];
    assign dataBit = dataSync[`SYNC_STAGES-1];

    always_ff @(posedge fclk or negedge rst) begin
        if (!rst) begin
            bitCnt    <= '0;
            codeValid <= 1'b0;
        end else begin
            codeValid <= 1'b0;
            if (clkFall) begin
                if (bitCnt == '0) begin
                    if (!dataBit)
                        bitCnt <= CntW'(1);   // Start bit
                end else if (bitCnt == CntW'(`PS2_FRAME_BITS - 1)) begin
                    // Stop must be high and parity odd
                    codeValid <= dataBit & (^{shiftReg, parityBit});
                    bitCnt    <= '0;
                end else begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge fclk) begin
        if (clkFall && bitCnt != '0) begin
            if (bitCnt < CntW'(`PS2_FRAME_BITS - 2))
                shiftReg <= {dataBit, shiftReg[`SCAN_W-1:1]};   // LSB first
            else if (bitCnt == CntW'(`PS2_FRAME_BITS - 2))
                parityBit <= dataBit;
        end
    end

    assign code = shiftReg;

endmodule

`default_nettype wire

//--- hdl/scanDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "ps2Kbd_macros.svh"

module scanDecoder (
    input  wire logic                fclk,
    input  wire logic                rst,
    input  wire logic                codeValid,
    input  wire ps2KbdPkg::scanCodeT code,
    keyEventIf.src                   ev
);
    import ps2KbdPkg::*;

    decStateT state;
    logic     caps;
    logic     press;   // Event payload for the current byte
    charCodeT chr;

    always_comb begin
        press = 1'b1;
        chr   = '0;
        if (code == `CODE_BREAK) begin
            press = 1'b0;
        end else begin
            case (state)
                stNormal:
                    if (code == `CODE_EXT)
                        press = 1'b0;
                    else if (code != `CODE_CAPS)
                        chr = translateScan(code, caps);
                stExtended:
                    case (code)
                        `CODE_UP:    chr = `CHAR_UP;
                        `CODE_DOWN:  chr = `CHAR_DOWN;
                        `CODE_LEFT:  chr = `CHAR_LEFT;
                        `CODE_RIGHT: chr = `CHAR_RIGHT;
                        default:     chr = '0;
                    endcase
                default:
                    press = 1'b0;   // Byte after F0 is swallowed
            endcase
        end
    end

    always_ff @(posedge fclk or negedge rst) begin
        if (!rst) begin
            state      <= stNormal;
            caps       <= 1'b0;
            ev.evValid <= 1'b0;
        end else begin
            ev.evValid <= codeValid;
            if (codeValid) begin
                if (code == `CODE_BREAK)
                    state <= stRelease;
                else if (state == stNormal && code == `CODE_EXT)
                    state <= stExtended;
                else
                    state <= stNormal;
                if (state == stNormal && code == `CODE_CAPS)
                    caps <= ~caps;
            end
        end
    end

    always_ff @(posedge fclk) begin
        if (codeValid) begin
            ev.evPress <= press;
            ev.evScan  <= code;
            ev.evChar  <= chr;
        end
    end

endmodule

`default_nettype wire

//--- hdl/keyOutReg.sv
`timescale 1ns/1ps
`default_nettype none

module keyOutReg (
    input  wire logic           fclk,
    input  wire logic           rst,
    keyEventIf.dst              ev,
    input  wire logic           rd,
    output ps2KbdPkg::scanCodeT scancode,
    output ps2KbdPkg::charCodeT asciiCode,
    output logic                dataReady
);

    always_ff @(posedge fclk or negedge rst) begin
        if (!rst) begin
            scancode  <= '0;
            asciiCode <= '0;
            dataReady <= 1'b0;
        end else begin
            // Every byte is latched, presses and prefixes alike
            if (ev.evValid) begin
                scancode  <= ev.evScan;
                asciiCode <= ev.evChar;
            end
            if (ev.evValid && ev.evPress)
                dataReady <= 1'b1;   // Press beats rd
            else if (rd)
                dataReady <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ps2Kbd.sv
`timescale 1ns/1ps
`default_nettype none

module ps2Kbd (
    input  wire logic           fclk,
    input  wire logic           rst,
    input  wire logic           ps2Clk,
    input  wire logic           ps2Data,
    input  wire logic           rd,
    output ps2KbdPkg::scanCodeT scancode,
    output ps2KbdPkg::charCodeT asciiCode,
    output logic                dataReady
);
    import ps2KbdPkg::*;

    logic     codeValid;
    scanCodeT code;

    keyEventIf ev ();

    ps2FrameRx rx0 (
        .fclk      (fclk),
        .rst       (rst),
        .ps2Clk    (ps2Clk),
        .ps2Data   (ps2Data),
        .codeValid (codeValid),
        .code      (code)
    );

    scanDecoder dec0 (
        .fclk      (fclk),
        .rst       (rst),
        .codeValid (codeValid),
        .code      (code),
        .ev        (ev.src)
    );

    keyOutReg out0 (
        .fclk      (fclk),
        .rst       (rst),
        .ev        (ev.dst),
        .rd        (rd),
        .scancode  (scancode),
        .asciiCode (asciiCode),
        .dataReady (dataReady)
    );

endmodule

`default_nettype wire

//--- tests/tbPs2Kbd.sv
`timescale 1ns/1ps
`default_nettype none

module tbPs2Kbd;
    localparam int HalfBit      = 20;    // fclk cycles per keyboard clock phase
    localparam int ReadyTimeout = 500;

    typedef struct packed {
        logic [7:0]  code;
        logic        badPar;
        logic        badStop;
        logic        expReady;
        logic [7:0]  expScan;
        logic [15:0] expChar;
        logic        doRd;
    } stepT;

    logic        fclk;
    logic        rst;
    logic        ps2Clk;
    logic        ps2Data;
    logic        rd;
    logic [7:0]  scancode;
    logic [15:0] asciiCode;
    logic        dataReady;

    integer seed = 32'h71d3;
    stepT   steps[$];

    ps2Kbd dut0 (
        .fclk      (fclk),
        .rst       (rst),
        .ps2Clk    (ps2Clk),
        .ps2Data   (ps2Data),
        .rd        (rd),
        .scancode  (scancode),
        .asciiCode (asciiCode),
        .dataReady (dataReady)
    );

    always #4 fclk = ~fclk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp)
            failRun($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic addStep(input logic [7:0] code, input logic badPar, input logic badStop,
                           input logic expReady, input logic [7:0] expScan,
                           input logic [15:0] expChar, input logic doRd);
        stepT s;
        s = '{code, badPar, badStop, expReady, expScan, expChar, doRd};
        steps.push_back(s);
    endtask

    // Keyboard side of one frame
    task automatic sendFrame(input logic [7:0] b, input logic badPar, input logic badStop);
        logic [10:0] bits;
        bits = {~badStop, ~(^b) ^ badPar, b, 1'b0};   // Stop, odd parity, data, start
        for (int i = 0; i < 11; i++) begin
            @(posedge fclk);
            ps2Data <= bits[i];   // Changes while keyboard clock is high
            repeat (HalfBit) @(posedge fclk);
            ps2Clk <= 1'b0;
            repeat (HalfBit) @(posedge fclk);
            ps2Clk <= 1'b1;
        end
        @(posedge fclk);
        ps2Data <= 1'b1;
    endtask

    task automatic waitReady(input logic expReady);
        int n;
        if (expReady) begin
            for (n = 0; n < ReadyTimeout && !dataReady; n++)
                @(negedge fclk);
            if (!dataReady)
                failRun("timeout while waiting for dataReady after a key press");
        end else begin
            repeat (ReadyTimeout) @(negedge fclk);   // No press may show in this window
        end
    endtask

    task automatic pulseRd();
        @(posedge fclk);
        rd <= 1'b1;
        @(posedge fclk);
        rd <= 1'b0;
        @(negedge fclk);
        checkVal("dataReady", {15'h0, dataReady}, 16'h0000);   // Cleared by rd
    endtask

    task automatic buildTable();
        // code   par   stop  rdy   scan   char      rd
        addStep(8'h1C, 1'b0, 1'b0, 1'b1, 8'h1C, 16'h0061, 1'b1);
        addStep(8'h2E, 1'b0, 1'b0, 1'b1, 8'h2E, 16'h0035, 1'b1);
        addStep(8'h58, 1'b0, 1'b0, 1'b1, 8'h58, 16'h0000, 1'b1);   // Caps on
        addStep(8'h1C, 1'b0, 1'b0, 1'b1, 8'h1C, 16'h0041, 1'b1);
        addStep(8'h1E, 1'b0, 1'b0, 1'b1, 8'h1E, 16'h0040, 1'b1);
        addStep(8'h58, 1'b0, 1'b0, 1'b1, 8'h58, 16'h0000, 1'b1);   // Caps off
        addStep(8'h1C, 1'b0, 1'b0, 1'b1, 8'h1C, 16'h0061, 1'b1);
        addStep(8'hF0, 1'b0, 1'b0, 1'b0, 8'hF0, 16'h0000, 1'b0);   // Release A
        addStep(8'h1C, 1'b0, 1'b0, 1'b0, 8'h1C, 16'h0000, 1'b0);
        addStep(8'hE0, 1'b0, 1'b0, 1'b0, 8'hE0, 16'h0000, 1'b0);
        addStep(8'h75, 1'b0, 1'b0, 1'b1, 8'h75, 16'h0100, 1'b1);   // Up
        addStep(8'hE0, 1'b0, 1'b0, 1'b0, 8'hE0, 16'h0000, 1'b0);
        addStep(8'h6B, 1'b0, 1'b0, 1'b1, 8'h6B, 16'h0102, 1'b1);   // Left
        addStep(8'hE0, 1'b0, 1'b0, 1'b0, 8'hE0, 16'h0000, 1'b0);   // Up released
        addStep(8'hF0, 1'b0, 1'b0, 1'b0, 8'hF0, 16'h0000, 1'b0);
        addStep(8'h75, 1'b0, 1'b0, 1'b0, 8'h75, 16'h0000, 1'b0);
        addStep(8'h2E, 1'b1, 1'b0, 1'b0, 8'h75, 16'h0000, 1'b0);   // Bad parity
        addStep(8'h1C, 1'b0, 1'b1, 1'b0, 8'h75, 16'h0000, 1'b0);   // Low stop bit
        addStep(8'h2E, 1'b0, 1'b0, 1'b1, 8'h2E, 16'h0035, 1'b1);
        addStep(8'h54, 1'b0, 1'b0, 1'b1, 8'h54, 16'h005B, 1'b1);
        addStep(8'h66, 1'b0, 1'b0, 1'b1, 8'h66, 16'h0008, 1'b1);
        addStep(8'h58, 1'b0, 1'b0, 1'b1, 8'h58, 16'h0000, 1'b1);
        addStep(8'h36, 1'b0, 1'b0, 1'b1, 8'h36, 16'h005E, 1'b1);
        addStep(8'h58, 1'b0, 1'b0, 1'b1, 8'h58, 16'h0000, 1'b1);
    endtask

    initial begin
        stepT s;
        int   gap;
        fclk    = 1'b0;
        rst     = 1'b0;
        ps2Clk  = 1'b1;
        ps2Data = 1'b1;
        rd      = 1'b0;
        repeat (8) @(posedge fclk);
        rst <= 1'b1;
        @(negedge fclk);
        checkVal("dataReady", {15'h0, dataReady}, 16'h0000);
        checkVal("scancode", {8'h00, scancode}, 16'h0000);
        checkVal("asciiCode", asciiCode, 16'h0000);
        buildTable();
        foreach (steps[i]) begin
            s   = steps[i];
            gap = 40 + ($random(seed) & 63);   // Idle line between frames
            repeat (gap) @(posedge fclk);
            sendFrame(s.code, s.badPar, s.badStop);
            waitReady(s.expReady);
            checkVal("dataReady", {15'h0, dataReady}, {15'h0, s.expReady});
            checkVal("scancode", {8'h00, scancode}, {8'h00, s.expScan});
            checkVal("asciiCode", asciiCode, s.expChar);
            if (s.doRd)
                pulseRd();
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- ps2Kbd.f
+incdir+hdl
hdl/ps2KbdPkg.sv
hdl/keyEventIf.sv
hdl/ps2FrameRx.sv
hdl/scanDecoder.sv
hdl/keyOutReg.sv
hdl/ps2Kbd.sv
tests/tbPs2Kbd.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f ps2Kbd.f --top-module tbPs2Kbd
./obj_dir/VtbPs2Kbd > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
